// ==== hw/stringAccel_config.svh ====
// String accelerator configuration
`ifndef STRING_ACCEL_CONFIG_SVH
`define STRING_ACCEL_CONFIG_SVH

// FIFO depth in words, fixed by the register map
`define STRING_MAX_WORDS 4

// Avalon data and address widths
`define STRING_WORD_BITS 32
`define STRING_ADDR_BITS 3

// Index reported when the key never shows up
`define STRING_NOT_FOUND 16'hFFFF

`endif

// ==== hw/avalonPkg.sv ====
// Avalon bus types
`include "stringAccel_config.svh"

package avalonPkg;

	// One data word on the bus
	typedef logic [`STRING_WORD_BITS-1:0] busWord;

	// Register address
	typedef logic [`STRING_ADDR_BITS-1:0] busAddr;

	// Slave-side request from the interconnect
	typedef struct packed {
		logic chipselect;
		logic read;
		logic write;
		busAddr address;
		busWord writedata;
	} busRequest;

	// Register map
	typedef enum busAddr {
		regData = 0,
		regKey = 1,
		regControl = 2,
		regResult = 3
	} regAddr;

endpackage

// ==== hw/stringPkg.sv ====
// String scan types
`include "stringAccel_config.svh"

package stringPkg;

	// One ASCII character
	typedef logic [7:0] charByte;

	// FIFO fill level, 0 up to full depth
	typedef logic [$clog2(`STRING_MAX_WORDS + 1)-1:0] fifoCount;

	// Byte position or string length
	typedef logic [15:0] charIndex;

	// Start request toward the scanner
	typedef struct packed {
		logic go;
		charByte key;
	} scanCommand;

	// Scanner status, all levels
	typedef struct packed {
		logic busy;
		logic done;
		charIndex length;
		charIndex index;
	} scanResult;

	// Scanner FSM
	typedef enum logic [1:0] {
		idle,
		fetch,
		inspect,
		finish
	} scanState;

endpackage

// ==== hw/avalonRegisterFile.sv ====
// Avalon register front end
`include "stringAccel_config.svh"

module avalonRegisterFile (
	input  logic                  clk,
	input  logic                  reset,
	input  avalonPkg::busRequest  request,
	input  stringPkg::fifoCount   count,
	input  avalonPkg::busWord     headWord,
	input  stringPkg::scanResult  result,
	output logic                  pushValid,
	output logic                  flush,
	output avalonPkg::busWord     pushData,
	output stringPkg::scanCommand command,
	output avalonPkg::busWord     readdata
);

	// Bus strobes
	logic writeStrobe;
	logic readStrobe;
	logic writeKey;
	logic writeControl;
	avalonPkg::regAddr address;

	// Key register and next read value
	stringPkg::charByte key;
	avalonPkg::busWord readNext;

	assign address = avalonPkg::regAddr'(request.address);
	assign writeStrobe = request.chipselect && request.write;
	assign readStrobe = request.chipselect && request.read;

	// Per-register write decode
	assign writeKey = writeStrobe && (address == avalonPkg::regKey);
	assign writeControl = writeStrobe && (address == avalonPkg::regControl);

	// Data writes go straight to the FIFO
	// full FIFO discards them on its own
	assign pushValid = writeStrobe && (address == avalonPkg::regData);
	assign pushData = request.writedata;

	// Control bit 1 empties the FIFO
	assign flush = writeControl && request.writedata[1];

	// Control bit 0 starts a scan, key rides along as a level
	always_comb begin
		command.go = writeControl && request.writedata[0];
		command.key = key;
	end

	// Search character
	always_ff @(posedge clk) begin
		if (reset) begin
			key <= '0;
		end else if (writeKey) begin
			key <= request.writedata[$bits(key)-1:0];
		end
	end

	// Read mux
	always_comb begin
		readNext = '0;
		case (address)
			avalonPkg::regData: begin
				// Peek only, the head stays in the FIFO
				readNext = headWord;
			end
			avalonPkg::regKey: begin
				readNext[$bits(key)-1:0] = key;
			end
			avalonPkg::regControl: begin
				readNext[0] = result.done;
				readNext[1] = result.busy;
				readNext[2 +: $bits(count)] = count;
			end
			avalonPkg::regResult: begin
				readNext[`STRING_WORD_BITS-1 -: $bits(result.index)] = result.index;
				readNext[$bits(result.length)-1:0] = result.length;
			end
			default: begin
				readNext = '0;
			end
		endcase
	end

	// Fixed read latency of one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			readdata <= '0;
		end else if (readStrobe) begin
			readdata <= readNext;
		end
	end

	// Host never strobes read and write in one transfer
	assert property (@(posedge clk) disable iff (reset)
		request.chipselect |-> !(request.read && request.write))
		else $error("read and write strobed together");

endmodule

// ==== hw/wordFifo.sv ====
// Circular word FIFO
`include "stringAccel_config.svh"

module wordFifo (
	input  logic                clk,
	input  logic                reset,
	input  logic                pushValid,
	input  logic                pop,
	input  logic                flush,
	input  avalonPkg::busWord   pushData,
	output avalonPkg::busWord   headWord,
	output stringPkg::fifoCount count,
	output logic                notEmpty
);

	// Pointer into the storage array
	typedef logic [$clog2(`STRING_MAX_WORDS)-1:0] fifoPtr;

	avalonPkg::busWord storage [`STRING_MAX_WORDS];
	fifoPtr readPtr;
	fifoPtr writePtr;
	logic full;
	logic doPush;

	assign full = (count == `STRING_MAX_WORDS);
	assign notEmpty = (count != '0);

	// Pushes into a full FIFO are lost
	assign doPush = pushValid && !full;

	// Oldest word, visible without popping
	assign headWord = storage[readPtr];

	// Payload storage
	always_ff @(posedge clk) begin
		if (doPush && !flush) begin
			storage[writePtr] <= pushData;
		end
	end

	// Pointers and fill level, flush wins over push and pop
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			readPtr <= '0;
			writePtr <= '0;
			count <= '0;
		end else begin
			if (doPush) begin
				writePtr <= (writePtr == fifoPtr'(`STRING_MAX_WORDS - 1)) ? '0 : writePtr + 1'b1;
			end
			if (pop) begin
				readPtr <= (readPtr == fifoPtr'(`STRING_MAX_WORDS - 1)) ? '0 : readPtr + 1'b1;
			end
			// Simultaneous push and pop leaves the level alone
			case ({doPush, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Fill level stays within depth
	assert property (@(posedge clk) disable iff (reset)
		count <= `STRING_MAX_WORDS)
		else $error("FIFO count above depth");

	// Scanner only pops a non-empty FIFO
	assert property (@(posedge clk) disable iff (reset)
		pop |-> notEmpty)
		else $error("pop while FIFO empty");

endmodule

// ==== hw/stringScanner.sv ====
// String length and key scanner
`include "stringAccel_config.svh"

module stringScanner (
	input  logic                  clk,
	input  logic                  reset,
	input  stringPkg::scanCommand command,
	input  logic                  notEmpty,
	input  avalonPkg::busWord     headWord,
	output logic                  pop,
	output stringPkg::scanResult  result
);

	stringPkg::scanState state;
	stringPkg::charByte key;

	// Word under inspection
	avalonPkg::busWord word;

	// Running results
	stringPkg::charIndex length;
	stringPkg::charIndex index;

	// Per-word inspection results
	logic hitTerm;
	logic matchHit;
	stringPkg::charIndex bytesBefore;
	stringPkg::charIndex matchPos;

	// One pop per fetch, only with data waiting
	assign pop = (state == stringPkg::fetch) && notEmpty;

	always_comb begin
		result.busy = (state == stringPkg::fetch) || (state == stringPkg::inspect);
		result.done = (state == stringPkg::finish);
		result.length = length;
		result.index = index;
	end

	// Walk the four bytes, lowest first
	always_comb begin
		hitTerm = 1'b0;
		matchHit = 1'b0;
		bytesBefore = '0;
		matchPos = '0;
		for (int i = 0; i < `STRING_WORD_BITS / 8; i++) begin
			if (!hitTerm) begin
				if (word[8*i +: 8] == 8'h00) begin
					hitTerm = 1'b1;
				end else begin
					// Only bytes ahead of the terminator can match
					if (!matchHit && (word[8*i +: 8] == key)) begin
						matchHit = 1'b1;
						matchPos = stringPkg::charIndex'(i);
					end
					bytesBefore = bytesBefore + 1'b1;
				end
			end
		end
	end

	// Scan FSM
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stringPkg::idle;
		end else begin
			case (state)
				stringPkg::idle, stringPkg::finish: begin
					// Go while busy never reaches here
					if (command.go) begin
						state <= stringPkg::fetch;
					end
				end
				stringPkg::fetch: begin
					// Out of words ends the scan
					state <= notEmpty ? stringPkg::inspect : stringPkg::finish;
				end
				stringPkg::inspect: begin
					state <= hitTerm ? stringPkg::finish : stringPkg::fetch;
				end
				default: state <= stringPkg::idle;
			endcase
		end
	end

	// Key latch, captured word and running counts
	always_ff @(posedge clk) begin
		if (reset) begin
			length <= '0;
			index <= `STRING_NOT_FOUND;
		end else if (command.go && (state == stringPkg::idle || state == stringPkg::finish)) begin
			length <= '0;
			index <= `STRING_NOT_FOUND;
		end else if (state == stringPkg::inspect) begin
			length <= length + bytesBefore;
			// First match only
			if (matchHit && (index == `STRING_NOT_FOUND)) begin
				index <= length + matchPos;
			end
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (command.go && (state == stringPkg::idle || state == stringPkg::finish)) begin
			key <= command.key;
		end
		if (pop) begin
			word <= headWord;
		end
	end

	// Done and busy are exclusive
	assert property (@(posedge clk) disable iff (reset)
		!(result.done && result.busy))
		else $error("done and busy both high");

endmodule

// ==== hw/stringAccelerator.sv ====
// String accelerator top level
`include "stringAccel_config.svh"

module stringAccelerator (
	input  logic                 clk,
	input  logic                 reset,
	input  avalonPkg::busRequest request,
	output avalonPkg::busWord    readdata
);

	// Register file to FIFO
	logic pushValid;
	logic flush;
	avalonPkg::busWord pushData;

	// FIFO status and head
	stringPkg::fifoCount count;
	avalonPkg::busWord headWord;
	logic notEmpty;

	// Scanner handshake
	logic pop;
	stringPkg::scanCommand command;
	stringPkg::scanResult result;

	// Producer
	avalonRegisterFile u_registerFile (
		.clk(clk),
		.reset(reset),
		.request(request),
		.count(count),
		.headWord(headWord),
		.result(result),
		.pushValid(pushValid),
		.flush(flush),
		.pushData(pushData),
		.command(command),
		.readdata(readdata)
	);

	// Buffer
	wordFifo u_wordFifo (
		.clk(clk),
		.reset(reset),
		.pushValid(pushValid),
		.pop(pop),
		.flush(flush),
		.pushData(pushData),
		.headWord(headWord),
		.count(count),
		.notEmpty(notEmpty)
	);

	// Consumer
	stringScanner u_stringScanner (
		.clk(clk),
		.reset(reset),
		.command(command),
		.notEmpty(notEmpty),
		.headWord(headWord),
		.pop(pop),
		.result(result)
	);

endmodule

// ==== verification/stringAcceleratorTb.sv ====
// String accelerator testbench
module stringAcceleratorTb;

	logic clk;
	logic reset;
	avalonPkg::busRequest request;
	avalonPkg::busWord readdata;

	// Vector table, one entry per file line
	int testList[$];
	logic [7:0] opList[$];
	logic [2:0] addrList[$];
	logic [31:0] dataList[$];
	logic [31:0] expList[$];

	// Bookkeeping
	int checkCount = 0;
	int errorCount = 0;
	int testErrors = 0;
	int testCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0;
	logic [31:0] randState = 32'hbc6b69d7;

	stringAccelerator u_stringAccelerator (
		.clk(clk),
		.reset(reset),
		.request(request),
		.readdata(readdata)
	);

	always #50 clk = ~clk;

	// Watchdog sized from the vector count
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
			$display("timeout reached after %0d cycles", cycleCount);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// LCG step
	function automatic logic [31:0] nextRandom(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic compareValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			testErrors++;
			$display("mismatch %s: got %h expected %h", name, actual, expected);
		end
	endtask

	// Single write transfer
	task automatic busWrite(input logic [2:0] addr, input logic [31:0] data);
		@(posedge clk);
		#10;
		request.chipselect = 1'b1;
		request.write = 1'b1;
		request.address = addr;
		request.writedata = data;
		@(posedge clk);
		#10;
		request = '0;
	endtask

	// Read with one cycle latency, sampled away from the edge
	task automatic busRead(input logic [2:0] addr, output logic [31:0] value);
		@(posedge clk);
		#10;
		request.chipselect = 1'b1;
		request.read = 1'b1;
		request.address = addr;
		@(posedge clk);
		#10;
		request = '0;
		value = readdata;
	endtask

	task automatic reportTest(input int number);
		testCount++;
		$display("test %0d %s, %0d errors", number, (testErrors == 0) ? "ok" : "bad", testErrors);
		testErrors = 0;
	endtask

	// Returns 0 when the file cannot be opened
	function automatic int loadVectors();
		int fd;
		int n;
		int t;
		logic [7:0] op;
		logic [2:0] a;
		logic [31:0] d;
		logic [31:0] e;
		logic [8*128-1:0] lineBuf;
		fd = $fopen("verification/stringVectors.txt", "r");
		if (fd == 0) begin
			return 0;
		end
		while (!$feof(fd)) begin
			lineBuf = '0;
			void'($fgets(lineBuf, fd));
			n = $sscanf(lineBuf, "%d %s %h %h %h", t, op, a, d, e);
			// Comment and blank lines fall out here
			if (n == 5) begin
				testList.push_back(t);
				opList.push_back(op);
				addrList.push_back(a);
				dataList.push_back(d);
				expList.push_back(e);
			end
		end
		$fclose(fd);
		return 1;
	endfunction

	task automatic runVectors();
		int currentTest;
		logic [31:0] value;
		currentTest = testList[0];
		for (int i = 0; i < testList.size(); i++) begin
			if (testList[i] != currentTest) begin
				reportTest(currentTest);
				currentTest = testList[i];
			end
			// Idle gap of 0 to 3 cycles
			randState = nextRandom(randState);
			repeat (randState[17:16]) @(posedge clk);
			case (opList[i])
				"W": busWrite(addrList[i], dataList[i]);
				"R": begin
					busRead(addrList[i], value);
					compareValue($sformatf("readdata[%0d]", addrList[i]), value, expList[i]);
				end
				"P": begin
					// Wait for done, busy covers every cycle before it
					do begin
						busRead(avalonPkg::regControl, value);
						if (value[0] !== 1'b1) begin
							compareValue("readdata[2] busy", value[1], 1'b1);
						end
					end while (value[0] !== 1'b1);
				end
				default: begin
					errorCount++;
					testErrors++;
					$display("unknown operation %c on vector %0d", opList[i], i);
				end
			endcase
		end
		reportTest(currentTest);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		request = '0;
		if (loadVectors() == 0 || testList.size() == 0) begin
			$display("vector file missing or empty");
			$display("CHECKS FAILED");
			$finish;
		end else begin
			cycleLimit = testList.size() * 40;
			repeat (3) @(posedge clk);
			#10;
			reset = 1'b0;
			runVectors();
			$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
			if (errorCount == 0) begin
				$display("ALL CHECKS PASSED");
			end else begin
				$display("CHECKS FAILED");
			end
			$finish;
		end
	end

endmodule

// ==== sources.f ====
+incdir+hw
hw/avalonPkg.sv
hw/stringPkg.sv
hw/avalonRegisterFile.sv
hw/wordFifo.sv
hw/stringScanner.sv
hw/stringAccelerator.sv
verification/stringAcceleratorTb.sv

// ==== verification/stringVectors.txt ====
# columns: test op addr data expected, all hex except test
# W writes data, R compares readdata with expected, P polls regControl until done
1 R 3 00000000 ffff0000
1 W 0 11223344 00000000
1 W 0 55667788 00000000
1 W 0 99aabbcc 00000000
1 R 2 00000000 0000000c
1 R 0 00000000 11223344
2 W 2 00000002 00000000
2 R 2 00000000 00000000
2 W 0 a0a1a2a3 00000000
2 W 0 b0b1b2b3 00000000
2 W 0 c0c1c2c3 00000000
2 W 0 d0d1d2d3 00000000
2 W 0 e0e1e2e3 00000000
2 W 0 f0f1f2f3 00000000
2 R 2 00000000 00000010
2 R 0 00000000 a0a1a2a3
3 W 2 00000002 00000000
3 W 1 0000006c 00000000
3 R 1 00000000 0000006c
3 W 0 6c6c6568 00000000
3 W 0 0000006f 00000000
3 W 2 00000001 00000000
3 P 2 00000000 00000000
3 R 3 00000000 00020005
3 R 2 00000000 00000001
4 W 1 0000007a 00000000
4 W 0 00636261 00000000
4 W 2 00000001 00000000
4 P 2 00000000 00000000
4 R 3 00000000 ffff0003
4 W 1 00000071 00000000
4 W 0 71006261 00000000
4 W 2 00000001 00000000
4 P 2 00000000 00000000
4 R 3 00000000 ffff0002
5 W 1 00000050 00000000
5 W 0 44434241 00000000
5 W 0 48474645 00000000
5 W 0 4c4b5049 00000000
5 W 0 514f4e4d 00000000
5 R 2 00000000 00000011
5 W 2 00000001 00000000
5 P 2 00000000 00000000
5 R 3 00000000 00090010
5 R 2 00000000 00000001
6 W 0 12345678 00000000
6 W 0 9abcdef0 00000000
6 R 2 00000000 00000009
6 W 2 00000002 00000000
6 R 2 00000000 00000001
6 W 2 00000001 00000000
6 P 2 00000000 00000000
6 R 3 00000000 ffff0000
6 R 2 00000000 00000001
